// ==== common/s1c88_pkg.sv ====
package s1c88_pkg;

    // bus_status encoding on the external bus
    localparam logic [1:0] BUS_STATUS_IDLE      = 2'd0;
    localparam logic [1:0] BUS_STATUS_MEM_WRITE = 2'd2;
    localparam logic [1:0] BUS_STATUS_MEM_READ  = 2'd3;

    typedef enum logic [2:0] {
        STATE_IDLE          = 3'd0,
        STATE_VECTOR_READ   = 3'd1,
        STATE_OPEXT_READ    = 3'd2,
        STATE_IMM_LOW_READ  = 3'd3,
        STATE_IMM_HIGH_READ = 3'd4,
        STATE_EXECUTE       = 3'd5
    } state_t;

    localparam logic [2:0] MICRO_TYPE_MISC = 3'd0;
    localparam logic [2:0] MICRO_TYPE_BUS  = 3'd1;

    localparam logic MICRO_BUS_READ  = 1'b0;
    localparam logic MICRO_BUS_WRITE = 1'b1;

    // register codes, shared by move source/destination and bus register
    localparam logic [4:0] MICRO_MOV_NONE     = 5'h00;
    localparam logic [4:0] MICRO_MOV_IMM      = 5'h01;
    localparam logic [4:0] MICRO_MOV_IMM_HIGH = 5'h03;
    localparam logic [4:0] MICRO_MOV_BR       = 5'h0D;
    localparam logic [4:0] MICRO_MOV_EP       = 5'h11;
    localparam logic [4:0] MICRO_MOV_ALU_R    = 5'h13;
    localparam logic [4:0] MICRO_MOV_ALU_A    = 5'h14;

    // page addressing EP:BR:ll
    localparam logic [4:0] MICRO_ADD_BR = 5'h07;

    localparam logic [4:0] MICRO_ALU_NONE = 5'h00;
    localparam logic [4:0] MICRO_ALU_OR   = 5'h03;

    typedef struct packed {
        logic [2:0] op_type;
        logic       alu_size;
        logic [4:0] alu_op;
        logic       bus_dir;
        logic       last;
        logic       early;
        logic [4:0] dst;
        logic [4:0] src;
    } micro_mov_t;

    typedef struct packed {
        logic [2:0] op_type;
        logic       alu_size;
        logic [4:0] alu_op;
        logic       bus_dir;
        logic       last;
        logic       early;
        logic [4:0] addr_mode;
        logic [4:0] bus_reg;
    } micro_bus_t;

    // one 22-bit microinstruction, read as a move or as a bus access
    typedef union packed {
        micro_mov_t mov;
        micro_bus_t bus;
    } micro_op_t;

    localparam int MICRO_ROM_DEPTH   = 32;
    localparam int TRANSLATION_DEPTH = 768;

    localparam logic [7:0]  EXT_OPCODE_BASE     = 8'hCD;
    localparam logic [23:0] RESET_DUMMY_ADDRESS = 24'hDEFACE;
    localparam int          RESET_WAIT_CYCLES   = 2;
    localparam logic [23:0] RESET_VECTOR_LOW    = 24'h000000;

endpackage

// ==== common/s1c88_seq_if.sv ====
`timescale 1ns/1ps

interface s1c88_seq_if;
    import s1c88_pkg::*;

    logic       pk;
    logic       pl;
    state_t     state;
    state_t     next_state;
    // microinstruction of the bus cycle that starts at the next pl edge
    micro_op_t  micro_op;
    logic       fetch_opcode;
    logic [1:0] vector_step;
    logic       running;
    logic       alu_b_imm8;
    logic [7:0] opcode;
    logic [7:0] opext;

    modport sequencer (
        output pk, pl, state, next_state, micro_op, fetch_opcode,
        output vector_step, running, alu_b_imm8,
        input  opcode, opext
    );

    modport datapath (
        input  pk, pl, state, next_state, micro_op, fetch_opcode,
        input  vector_step, running, alu_b_imm8,
        output opcode, opext
    );

endinterface

// ==== hw/sequencer/opcode_decode.sv ====
`timescale 1ns/1ps

module opcode_decode
(
    input  logic [7:0] opcode,
    input  logic [7:0] opext,
    output logic       need_opext,
    output logic       need_imm,
    output logic       imm_size,
    output logic       alu_b_imm8,
    output logic [9:0] ext_opcode
);
    import s1c88_pkg::*;

    logic [7:0] ext_num;

    assign need_opext = (opcode == 8'hCE) || (opcode == 8'hCF);
    // CE maps to table page 1, CF to page 2
    assign ext_num    = opcode - EXT_OPCODE_BASE;
    assign ext_opcode = need_opext ? {ext_num[1:0], opext} : {2'b00, opcode};

    always_comb
    begin
        need_imm   = (opcode == 8'hB4) || (opcode == 8'hDD) || (opcode == 8'hD9) ||
                     ((opcode == 8'hCE) && (opext == 8'hC5));
        // ll then nn
        imm_size   = (opcode == 8'hDD) || (opcode == 8'hD9);
        alu_b_imm8 = (opcode == 8'hD9);
    end

endmodule

// ==== hw/sequencer/microcode_rom.sv ====
`timescale 1ns/1ps

module microcode_rom
(
    input  logic [9:0]            ext_opcode,
    input  logic [8:0]            micro_address,
    input  logic [3:0]            micro_step,
    output logic [8:0]            entry,
    output s1c88_pkg::micro_op_t  micro_op
);
    import s1c88_pkg::*;

    logic [8:0] index;

    function automatic micro_op_t mov_step(input logic [4:0] dst, input logic [4:0] src);
        micro_op_t op;
        op.mov = '{op_type: MICRO_TYPE_MISC, alu_size: 1'b0, alu_op: MICRO_ALU_NONE,
                   bus_dir: MICRO_BUS_READ, last: 1'b1, early: 1'b1, dst: dst, src: src};
        return op;
    endfunction

    function automatic micro_op_t bus_step(input logic dir, input logic [4:0] alu,
                                           input logic [4:0] bus_reg);
        micro_op_t op;
        op.bus = '{op_type: MICRO_TYPE_BUS, alu_size: 1'b0, alu_op: alu, bus_dir: dir,
                   last: 1'b0, early: 1'b0, addr_mode: MICRO_ADD_BR, bus_reg: bus_reg};
        return op;
    endfunction

    // unlisted opcodes land on entry 0
    always_comb
    begin
        entry = 9'd0;
        if (int'(ext_opcode) < TRANSLATION_DEPTH)
        begin
            case (ext_opcode)
                10'h0B4: entry = 9'd1;
                10'h1C5: entry = 9'd2;
                10'h0DD: entry = 9'd3;
                10'h0D9: entry = 9'd5;
                default: entry = 9'd0;
            endcase
        end
    end

    assign index = micro_address + 9'(micro_step);

    always_comb
    begin
        micro_op = mov_step(MICRO_MOV_NONE, MICRO_MOV_NONE);
        if (int'(index) < MICRO_ROM_DEPTH)
        begin
            case (index[4:0])
                5'd1: micro_op = mov_step(MICRO_MOV_BR, MICRO_MOV_IMM);
                5'd2: micro_op = mov_step(MICRO_MOV_EP, MICRO_MOV_IMM);
                // LD [BR:ll],#nn
                5'd3: micro_op = bus_step(MICRO_BUS_WRITE, MICRO_ALU_NONE, MICRO_MOV_IMM_HIGH);
                // OR [BR:ll],#nn, read then write back
                5'd5: micro_op = bus_step(MICRO_BUS_READ, MICRO_ALU_NONE, MICRO_MOV_ALU_A);
                5'd6: micro_op = bus_step(MICRO_BUS_WRITE, MICRO_ALU_OR, MICRO_MOV_ALU_R);
                default: micro_op = mov_step(MICRO_MOV_NONE, MICRO_MOV_NONE);
            endcase
        end
    end

endmodule

// ==== hw/sequencer/s1c88_sequencer.sv ====
`timescale 1ns/1ps

module s1c88_sequencer
(
    input logic clk,
    input logic reset,
    s1c88_seq_if.sequencer seq
);
    import s1c88_pkg::*;

    logic [1:0] reset_count;
    logic [8:0] microaddress;
    logic [3:0] mpc;
    logic       cur_last;
    logic [8:0] up_address;
    logic [3:0] up_step;
    logic [8:0] entry;
    logic [9:0] ext_opcode;
    logic       need_opext;
    logic       need_imm;
    logic       imm_size;
    micro_op_t  up_op;

    opcode_decode decode_inst
    (
        .opcode     (seq.opcode),
        .opext      (seq.opext),
        .need_opext (need_opext),
        .need_imm   (need_imm),
        .imm_size   (imm_size),
        .alu_b_imm8 (seq.alu_b_imm8),
        .ext_opcode (ext_opcode)
    );

    microcode_rom rom_inst
    (
        .ext_opcode    (ext_opcode),
        .micro_address (up_address),
        .micro_step    (up_step),
        .entry         (entry),
        .micro_op      (up_op)
    );

    assign seq.micro_op = up_op;

    // the opcode fetched during the last step decides what follows
    always_comb
    begin
        unique case (seq.state)
            STATE_IDLE:
                seq.next_state = STATE_VECTOR_READ;
            STATE_VECTOR_READ:
                seq.next_state = (seq.vector_step == 2'd2) ? STATE_EXECUTE : STATE_VECTOR_READ;
            STATE_EXECUTE:
                if (!cur_last)
                    seq.next_state = STATE_EXECUTE;
                else if (need_opext)
                    seq.next_state = STATE_OPEXT_READ;
                else if (need_imm)
                    seq.next_state = STATE_IMM_LOW_READ;
                else
                    seq.next_state = STATE_EXECUTE;
            STATE_OPEXT_READ:
                seq.next_state = need_imm ? STATE_IMM_LOW_READ : STATE_EXECUTE;
            STATE_IMM_LOW_READ:
                seq.next_state = imm_size ? STATE_IMM_HIGH_READ : STATE_EXECUTE;
            default:
                seq.next_state = STATE_EXECUTE;
        endcase
    end

    // position of the upcoming micro step
    always_comb
    begin
        if (seq.state == STATE_EXECUTE && !cur_last)
        begin
            up_address = microaddress;
            up_step    = mpc + 4'd1;
        end
        else if (seq.state == STATE_VECTOR_READ)
        begin
            // first opcode fetch runs as the no-op at entry 0
            up_address = 9'd0;
            up_step    = 4'd0;
        end
        else
        begin
            up_address = entry;
            up_step    = 4'd0;
        end
    end

    always_ff @(negedge clk, posedge reset)
    begin
        if (reset)
        begin
            reset_count      <= 2'd0;
            seq.running      <= 1'b0;
            seq.pl           <= 1'b0;
            seq.state        <= STATE_IDLE;
            seq.vector_step  <= 2'd0;
            seq.fetch_opcode <= 1'b0;
            microaddress     <= 9'd0;
            mpc              <= 4'd0;
            cur_last         <= 1'b0;
        end
        else if (!seq.running)
        begin
            reset_count <= reset_count + 2'd1;
            if (reset_count == 2'(RESET_WAIT_CYCLES - 1))
                seq.running <= 1'b1;
        end
        else
        begin
            seq.pl <= ~seq.pl;
            if (seq.pl)
            begin
                seq.state        <= seq.next_state;
                seq.fetch_opcode <= (seq.next_state == STATE_EXECUTE) && up_op.mov.early;
                if (seq.state == STATE_VECTOR_READ)
                    seq.vector_step <= seq.vector_step + 2'd1;
                if (seq.next_state == STATE_EXECUTE)
                begin
                    microaddress <= up_address;
                    mpc          <= up_step;
                    cur_last     <= up_op.mov.last;
                end
            end
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            seq.pk <= 1'b0;
        else if (seq.running)
            seq.pk <= ~seq.pk;
    end

    a_state_legal: assert property (@(negedge clk) disable iff (reset)
        seq.state inside {STATE_IDLE, STATE_VECTOR_READ, STATE_OPEXT_READ,
                          STATE_IMM_LOW_READ, STATE_IMM_HIGH_READ, STATE_EXECUTE});

    a_no_fetch_in_imm: assert property (@(posedge clk) disable iff (reset)
        seq.state inside {STATE_IMM_LOW_READ, STATE_IMM_HIGH_READ} |-> !seq.fetch_opcode);

endmodule

// ==== hw/datapath/s1c88_datapath.sv ====
`timescale 1ns/1ps

module s1c88_datapath
(
    input  logic        clk,
    input  logic        reset,
    s1c88_seq_if.datapath seq,
    input  logic [7:0]  data_in,
    output logic [7:0]  data_out,
    output logic [23:0] address_out,
    output logic [1:0]  bus_status,
    output logic        read,
    output logic        write,
    output logic        sync
);
    import s1c88_pkg::*;

    logic [15:0] pc;
    logic [7:0]  imm_low;
    logic [7:0]  imm_high;
    logic [7:0]  ep;
    logic [7:0]  br;
    logic [7:0]  alu_a;
    logic [7:0]  alu_b;
    logic [7:0]  alu_r;
    logic [7:0]  mov_src;
    micro_op_t   cur_op;
    logic        up_exec;
    logic        up_bus;
    logic        cur_bus_read;
    logic        cur_bus_write;
    logic        operand_read;
    logic        vector_read;

    assign up_exec       = seq.next_state == STATE_EXECUTE;
    assign up_bus        = up_exec && seq.micro_op.bus.op_type == MICRO_TYPE_BUS;
    assign cur_bus_read  = seq.state == STATE_EXECUTE && cur_op.bus.op_type == MICRO_TYPE_BUS &&
                           cur_op.bus.bus_dir == MICRO_BUS_READ;
    assign cur_bus_write = seq.state == STATE_EXECUTE && cur_op.bus.op_type == MICRO_TYPE_BUS &&
                           cur_op.bus.bus_dir == MICRO_BUS_WRITE;
    assign operand_read  = seq.fetch_opcode ||
                           seq.state inside {STATE_OPEXT_READ, STATE_IMM_LOW_READ,
                                             STATE_IMM_HIGH_READ};
    assign vector_read   = seq.state == STATE_VECTOR_READ && seq.vector_step != 2'd0;

    // OR or pass-through
    assign alu_r = (cur_op.bus.alu_op == MICRO_ALU_OR) ? (alu_a | alu_b) : alu_a;

    assign write = seq.pl && seq.pk && cur_bus_write;
    assign sync  = seq.fetch_opcode;

    always_comb
    begin
        case (seq.micro_op.mov.src)
            MICRO_MOV_IMM:      mov_src = imm_low;
            MICRO_MOV_IMM_HIGH: mov_src = imm_high;
            MICRO_MOV_EP:       mov_src = ep;
            MICRO_MOV_BR:       mov_src = br;
            default:            mov_src = 8'h00;
        endcase
    end

    // address phase, one per bus cycle
    always_ff @(negedge clk, posedge reset)
    begin
        if (reset)
        begin
            address_out <= '1;
            bus_status  <= BUS_STATUS_IDLE;
            ep          <= 8'h00;
            br          <= 8'h00;
        end
        else if (seq.running && seq.pl)
        begin
            bus_status <= BUS_STATUS_IDLE;
            if (seq.state == STATE_IDLE)
                address_out <= RESET_DUMMY_ADDRESS;
            else if (seq.state == STATE_VECTOR_READ && seq.vector_step != 2'd2)
            begin
                address_out <= RESET_VECTOR_LOW + 24'(seq.vector_step);
                bus_status  <= BUS_STATUS_MEM_READ;
            end
            else if (up_bus && seq.micro_op.bus.addr_mode == MICRO_ADD_BR)
            begin
                address_out <= {ep, br, imm_low};
                bus_status  <= (seq.micro_op.bus.bus_dir == MICRO_BUS_WRITE) ?
                               BUS_STATUS_MEM_WRITE : BUS_STATUS_MEM_READ;
            end
            else if ((up_exec && seq.micro_op.mov.early) ||
                     seq.next_state inside {STATE_OPEXT_READ, STATE_IMM_LOW_READ,
                                            STATE_IMM_HIGH_READ})
            begin
                address_out <= {8'h00, pc};
                bus_status  <= BUS_STATUS_MEM_READ;
            end

            if (up_exec && !up_bus)
            begin
                case (seq.micro_op.mov.dst)
                    MICRO_MOV_EP: ep <= mov_src;
                    MICRO_MOV_BR: br <= mov_src;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(negedge clk)
    begin
        if (seq.running && seq.pl)
            cur_op <= seq.micro_op;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            read <= 1'b0;
            pc   <= 16'h0000;
        end
        else if (seq.running)
        begin
            read <= 1'b0;
            if (!seq.pk)
            begin
                read <= operand_read || cur_bus_read || vector_read;
                if (operand_read)
                    pc <= pc + 16'd1;
            end
            else if (vector_read)
            begin
                if (seq.vector_step == 2'd1)
                    pc[7:0] <= data_in;
                else
                    pc[15:8] <= data_in;
            end
        end
    end

    // read data capture at pk 1, write data at pk 0
    always_ff @(posedge clk)
    begin
        if (seq.running && seq.pk)
        begin
            if (seq.fetch_opcode)
                seq.opcode <= data_in;
            case (seq.state)
                STATE_OPEXT_READ:    seq.opext <= data_in;
                STATE_IMM_LOW_READ:  imm_low <= data_in;
                STATE_IMM_HIGH_READ: imm_high <= data_in;
                default: ;
            endcase
            if (seq.alu_b_imm8 && seq.state == STATE_IMM_HIGH_READ)
                alu_b <= data_in;
            if (cur_bus_read && cur_op.bus.bus_reg == MICRO_MOV_ALU_A)
                alu_a <= data_in;
        end
        else if (seq.running && cur_bus_write)
        begin
            data_out <= (cur_op.bus.bus_reg == MICRO_MOV_ALU_R) ? alu_r : imm_high;
        end
    end

    a_no_read_write: assert property (@(posedge clk) disable iff (reset)
        !(read && write));

    a_write_status: assert property (@(posedge clk) disable iff (reset)
        write |-> bus_status == BUS_STATUS_MEM_WRITE);

endmodule

// ==== hw/s1c88.sv ====
`timescale 1ns/1ps

module s1c88
(
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  data_in,
    output logic [7:0]  data_out,
    output logic [23:0] address_out,
    output logic [1:0]  bus_status,
    output logic        read,
    output logic        write,
    output logic        sync,
    output logic        pk,
    output logic        pl
);

    s1c88_seq_if seq_bus ();

    s1c88_sequencer sequencer_inst
    (
        .clk   (clk),
        .reset (reset),
        .seq   (seq_bus.sequencer)
    );

    s1c88_datapath datapath_inst
    (
        .clk         (clk),
        .reset       (reset),
        .seq         (seq_bus.datapath),
        .data_in     (data_in),
        .data_out    (data_out),
        .address_out (address_out),
        .bus_status  (bus_status),
        .read        (read),
        .write       (write),
        .sync        (sync)
    );

    // bus phases come out of the sequencer
    assign pk = seq_bus.pk;
    assign pl = seq_bus.pl;

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock
(
    output logic clk
);

    // 20 ns period
    localparam int HALF_PERIOD_NS = 10;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

endmodule

// ==== testbench/tb_s1c88.sv ====
`timescale 1ns/1ps

module tb_s1c88;
    import s1c88_pkg::*;

    localparam int          TIMEOUT_CYCLES = 400;
    localparam logic [23:0] START_ADDRESS  = 24'h000100;
    localparam logic [23:0] DATA_ADDRESS   = 24'h002040;
    localparam logic [7:0]  LD_VALUE       = 8'h5A;
    localparam logic [7:0]  OR_MASK        = 8'h0F;
    localparam logic [7:0]  OR_RESULT      = LD_VALUE | OR_MASK;

    logic        clk;
    logic        reset;
    logic [7:0]  data_in;
    logic [7:0]  data_out;
    logic [23:0] address_out;
    logic [1:0]  bus_status;
    logic        read;
    logic        write;
    logic        sync;
    logic        pk;
    logic        pl;

    logic [7:0]  mem [0:65535];
    int          seed;
    int          mismatch_count = 0;
    int          failure_count = 0;
    int          reset_edges = 0;
    int          read_count = 0;
    int          write_count = 0;
    logic        seen_dummy = 1'b0;
    logic        program_done = 1'b0;
    logic        timed_out = 1'b0;
    logic [23:0] prev_address = 24'h000000;
    logic        prev_sync = 1'b0;
    logic        phases_started = 1'b0;
    logic        last_pk = 1'b0;
    logic        last_pl = 1'b0;

    tb_clock clock_inst
    (
        .clk (clk)
    );

    s1c88 s1c88_inst
    (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .data_out    (data_out),
        .address_out (address_out),
        .bus_status  (bus_status),
        .read        (read),
        .write       (write),
        .sync        (sync),
        .pk          (pk),
        .pl          (pl)
    );

    task automatic report_mismatch(input string name, input logic [23:0] got,
                                   input logic [23:0] expected);
        mismatch_count++;
        $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
    endtask

    task automatic report_failure(input string what);
        failure_count++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic put_byte(input logic [15:0] address, input logic [7:0] value);
        mem[address] = value;
    endtask

    task automatic check_read_cycle();
        logic [23:0] expected;
        expected = prev_address + 24'd1;
        assert (bus_status == BUS_STATUS_MEM_READ)
            else report_mismatch("bus_status", 24'(bus_status), 24'(BUS_STATUS_MEM_READ));
        if (read_count == 0)
        begin
            assert (seen_dummy) else report_failure("dummy address not driven before first read");
        end
        if (read_count < 2)
        begin
            // reset vector, low byte first
            expected = RESET_VECTOR_LOW + 24'(read_count);
            assert (!sync) else report_failure("sync is high during a vector read");
        end
        else if (read_count == 2)
        begin
            expected = START_ADDRESS;
            assert (sync) else report_failure("first read after the vector is not an opcode fetch");
        end
        // opcode and operand reads run in sequence up to the first data access
        if (read_count <= 2 || write_count == 0)
        begin
            assert (address_out == expected)
                else report_mismatch("address_out", address_out, expected);
        end
        // the fetch after the OR write marks the end of the program
        if (sync && write_count == 2 && !program_done)
        begin
            assert (mem[DATA_ADDRESS[15:0]] == OR_RESULT)
                else report_mismatch("mem[2040]", 24'(mem[DATA_ADDRESS[15:0]]), 24'(OR_RESULT));
            program_done = 1'b1;
        end
        prev_address = address_out;
        prev_sync    = sync;
        read_count++;
    endtask

    task automatic check_write_cycle();
        logic [7:0] expected;
        expected = LD_VALUE;
        assert (bus_status == BUS_STATUS_MEM_WRITE)
            else report_mismatch("bus_status", 24'(bus_status), 24'(BUS_STATUS_MEM_WRITE));
        assert (address_out == DATA_ADDRESS)
            else report_mismatch("address_out", address_out, DATA_ADDRESS);
        if (write_count == 1)
        begin
            // read-modify-write, the operand comes from the same page address
            expected = OR_RESULT;
            assert (prev_address == DATA_ADDRESS && !prev_sync)
                else report_failure("OR did not read its operand before writing");
        end
        if (write_count > 1)
            report_failure("unexpected write after the program");
        else
        begin
            assert (data_out == expected)
                else report_mismatch("data_out", 24'(data_out), 24'(expected));
        end
        write_count++;
    endtask

    task automatic finish_run();
        int other_errors;
        other_errors = failure_count + (timed_out ? 1 : 0);
        $display("reads %0d, writes %0d, mismatches %0d, other errors %0d",
                 read_count, write_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    endtask

    // memory contents, then stores from the DUT
    initial
    begin
        seed = 39861;
        for (int a = 0; a < 65536; a++)
            mem[16'(a)] = 8'($random(seed));
        for (int a = 'h010B; a < 'h0200; a++)
            mem[16'(a)] = 8'h00;
        put_byte(16'h0000, 8'h00);
        put_byte(16'h0001, 8'h01);
        // LD BR,#20
        put_byte(16'h0100, 8'hB4);
        put_byte(16'h0101, 8'h20);
        // LD EP,#00
        put_byte(16'h0102, 8'hCE);
        put_byte(16'h0103, 8'hC5);
        put_byte(16'h0104, 8'h00);
        // LD [BR:40],#5A
        put_byte(16'h0105, 8'hDD);
        put_byte(16'h0106, 8'h40);
        put_byte(16'h0107, 8'h5A);
        // OR [BR:40],#0F
        put_byte(16'h0108, 8'hD9);
        put_byte(16'h0109, 8'h40);
        put_byte(16'h010A, 8'h0F);
        forever
        begin
            @(posedge clk);
            if (write)
                mem[address_out[15:0]] = data_out;
        end
    end

    // address is stable since the previous falling edge
    initial
    begin
        data_in = 8'h00;
        forever
        begin
            @(negedge clk);
            data_in <= mem[address_out[15:0]];
        end
    end

    always @(posedge clk)
    begin
        if (reset)
        begin
            reset_edges++;
            if (reset_edges > 1)
            begin
                assert (!read && !write && !sync) else report_failure("bus strobe active in reset");
                assert (!pk) else report_mismatch("pk", 24'(pk), 24'd0);
                assert (!pl) else report_mismatch("pl", 24'(pl), 24'd0);
                assert (bus_status == BUS_STATUS_IDLE)
                    else report_mismatch("bus_status", 24'(bus_status), 24'(BUS_STATUS_IDLE));
                assert (address_out == 24'hFFFFFF)
                    else report_mismatch("address_out", address_out, 24'hFFFFFF);
            end
        end
        else
        begin
            if (address_out == RESET_DUMMY_ADDRESS)
                seen_dummy = 1'b1;
            // pl toggles on every falling edge once the phases run
            if (pk)
                phases_started = 1'b1;
            if (phases_started)
            begin
                assert (pl != last_pl) else report_mismatch("pl", 24'(pl), 24'(!last_pl));
            end
            last_pl = pl;
            assert (!(read && write)) else report_failure("read and write are high together");
            if (read)
                check_read_cycle();
            if (write)
                check_write_cycle();
        end
    end

    // pk toggles on every rising edge once the phases run
    always @(negedge clk)
    begin
        if (!reset && phases_started)
        begin
            assert (pk != last_pk) else report_mismatch("pk", 24'(pk), 24'(!last_pk));
        end
        last_pk = pk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;
        wait (program_done);
        finish_run();
    end

    initial
    begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        timed_out = 1'b1;
        $display("Error at %0t ns: program did not finish within %0d cycles",
                 $time, TIMEOUT_CYCLES);
        finish_run();
    end

endmodule

// ==== files.f ====
common/s1c88_pkg.sv
common/s1c88_seq_if.sv
hw/sequencer/opcode_decode.sv
hw/sequencer/microcode_rom.sv
hw/sequencer/s1c88_sequencer.sv
hw/datapath/s1c88_datapath.sv
hw/s1c88.sv
testbench/tb_clock.sv
testbench/tb_s1c88.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the s1c88 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_s1c88 -f files.f -o sim_tb \
    || { echo "build failed"; exit 1; }

output=$(./obj_dir/sim_tb)
echo "$output"
echo "$output" | grep -qx "=== PASS ===" && exit 0 || exit 1
